/* hw/icache_cfg_pkg.sv */
// geometry of the instruction cache and the types derived from it
// imported by every RTL block that touches addresses, tags or lines
package icache_cfg_pkg;

  ////////////////////
  // basic sizes
  ////////////////////

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned FetchWidth = 32;
  localparam int unsigned LineWidth  = 128;
  localparam int unsigned NumWays    = 4;
  localparam int unsigned NumSets    = 64;

  ////////////////////
  // address split
  ////////////////////

  // byte offset inside one line
  localparam int unsigned OffsetWidth = $clog2(LineWidth / 8);
  localparam int unsigned IndexWidth  = $clog2(NumSets);
  // what is left above index and offset
  localparam int unsigned TagWidth    = AddrWidth - IndexWidth - OffsetWidth;
  localparam int unsigned WayIdxWidth = $clog2(NumWays);

  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [TagWidth-1:0]   tag_t;
  typedef logic [IndexWidth-1:0] set_idx_t;
  // one bit per way, used for hits, valids and the victim
  typedef logic [NumWays-1:0]    way_oh_t;
  typedef logic [LineWidth-1:0]  line_t;
  typedef logic [FetchWidth-1:0] word_t;

endpackage

/* hw/icache_mem_pkg.sv */
// packets on the memory return port of the instruction cache
// one return beat is a full line, read either as fill data or as an invalidation
package icache_mem_pkg;

  ////////////////////
  // return kind
  ////////////////////

  typedef enum logic {
    IFILL_ACK = 1'b0,
    INV_REQ   = 1'b1
  } rtrn_type_e;

  // bits left over once the invalidation fields are placed
  localparam int unsigned InvPadWidth = icache_cfg_pkg::LineWidth
                                      - icache_cfg_pkg::IndexWidth
                                      - icache_cfg_pkg::WayIdxWidth
                                      - 2;

  ////////////////////
  // invalidation
  ////////////////////

  // fields sit at the low end of the beat, upper bits carry nothing
  typedef struct packed {
    logic [InvPadWidth-1:0]                pad;
    // clear every way of the set
    logic                                  all;
    // clear only the way given below
    logic                                  vld;
    logic [icache_cfg_pkg::WayIdxWidth-1:0] way;
    icache_cfg_pkg::set_idx_t              idx;
  } inv_req_t;

  // line on IFILL_ACK, invalidation on INV_REQ
  typedef union packed {
    icache_cfg_pkg::line_t line;
    inv_req_t              inv;
  } rtrn_payload_u;

endpackage

/* hw/icache_repl.sv */
// victim choice for refills
// first invalid way, or a pseudo random way once the set is full
`timescale 1ns/1ns

module icache_repl #(
  parameter logic [7:0] LfsrSeed = 8'hA5
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_cfg_pkg::way_oh_t valid_i,
  input  logic                    fill_en_i,
  input  logic                    cmp_en_i,
  output icache_cfg_pkg::way_oh_t victim_o
);
  import icache_cfg_pkg::*;

  logic [7:0]             lfsr_q;
  logic [WayIdxWidth-1:0] inv_way;
  logic [WayIdxWidth-1:0] repl_way;
  logic                   all_valid;
  way_oh_t                victim_q;

  // scan from the top so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = w[WayIdxWidth-1:0];
      end
    end
  end

  assign all_valid = &valid_i;
  assign repl_way  = all_valid ? lfsr_q[WayIdxWidth-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= LfsrSeed;
      victim_q <= '0;
    end else begin
      // galois form, x^8 + x^6 + x^5 + x^4 + 1
      if (fill_en_i && all_valid) begin
        lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);
      end
      if (cmp_en_i) begin
        victim_q <= way_oh_t'(1) << repl_way;
      end
    end
  end

  assign victim_o = victim_q;

endmodule

/* hw/icache_tag_array.sv */
// tag and valid storage per way and set, with the tag compare
// written by fills, invalidations and flushes, read one set at a time
`timescale 1ns/1ns

module icache_tag_array (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rd_en_i,
  input  logic                     fill_en_i,
  input  logic                     inv_en_i,
  input  logic                     flush_en_i,
  input  icache_cfg_pkg::set_idx_t set_i,
  input  icache_cfg_pkg::tag_t     tag_i,
  input  icache_cfg_pkg::way_oh_t  victim_i,
  input  icache_mem_pkg::inv_req_t inv_i,
  output icache_cfg_pkg::way_oh_t  hit_o,
  output icache_cfg_pkg::way_oh_t  valid_o
);
  import icache_cfg_pkg::*;

  tag_t                    tag_mem [NumWays][NumSets];
  way_oh_t [NumSets-1:0]   valid_mem;
  tag_t                    rd_tag_q [NumWays];
  way_oh_t                 valid_q;
  way_oh_t                 clr_mask;
  logic                    vld_we;

  // ways to clear, flush wins over an invalidation
  always_comb begin
    clr_mask = '0;
    if (flush_en_i) begin
      clr_mask = '1;
    end else if (inv_en_i) begin
      if (inv_i.all) begin
        clr_mask = '1;
      end else if (inv_i.vld) begin
        clr_mask = way_oh_t'(1) << inv_i.way;
      end
    end
  end

  assign vld_we = flush_en_i | inv_en_i | fill_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_mem <= '0;
      valid_q   <= '0;
    end else begin
      if (vld_we) begin
        valid_mem[set_i] <= (valid_mem[set_i] & ~clr_mask) | (fill_en_i ? victim_i : '0);
      end
      if (rd_en_i) begin
        valid_q <= valid_mem[set_i];
      end
    end
  end

  // tags only change on a fill into the victim way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (fill_en_i && victim_i[w]) begin
        tag_mem[w][set_i] <= tag_i;
      end
      if (rd_en_i) begin
        rd_tag_q[w] <= tag_mem[w][set_i];
      end
    end
  end

  // compare against the tag of the fetch in flight
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      hit_o[w] = valid_q[w] & (rd_tag_q[w] == tag_i);
    end
  end

  assign valid_o = valid_q;

endmodule

/* hw/icache_data_array.sv */
// line storage per way, word select on a hit and bypass of the return line
// read one cycle after the strobe, written in the fill cycle
`timescale 1ns/1ns

module icache_data_array (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    rd_en_i,
  input  logic                                    fill_en_i,
  input  icache_cfg_pkg::set_idx_t                set_i,
  input  icache_cfg_pkg::way_oh_t                 victim_i,
  input  icache_cfg_pkg::way_oh_t                 hit_i,
  input  logic [icache_cfg_pkg::OffsetWidth-3:0]  offset_i,
  input  logic                                    bypass_i,
  input  icache_cfg_pkg::line_t                   fill_line_i,
  output icache_cfg_pkg::word_t                   fetch_data_o
);
  import icache_cfg_pkg::*;

  line_t data_mem [NumWays][NumSets];
  line_t rd_line_q [NumWays];
  word_t hit_word;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (fill_en_i && victim_i[w]) begin
        data_mem[w][set_i] <= fill_line_i;
      end
    end
  end

  // all ways read in parallel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_line_q <= '{default: '0};
    end else if (rd_en_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rd_line_q[w] <= data_mem[w][set_i];
      end
    end
  end

  ////////////////////
  // output mux
  ////////////////////

  // hit vector is one-hot, so an or of the ways is enough
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hit_i[w]) begin
        hit_word = hit_word | rd_line_q[w][offset_i*FetchWidth +: FetchWidth];
      end
    end
    fetch_data_o = bypass_i ? fill_line_i[offset_i*FetchWidth +: FetchWidth] : hit_word;
  end

endmodule

/* hw/icache_ctrl.sv */
// control FSM of the instruction cache: lookup, miss refill, flush and invalidations
// drives the tag and data arrays and both memory side ports
`timescale 1ns/1ns

module icache_ctrl #(
  parameter icache_cfg_pkg::addr_t NcBase = 32'h8000_0000
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  input  logic                                    en_i,
  output logic                                    busy_o,
  output logic                                    miss_o,
  input  logic                                    fetch_req_i,
  input  icache_cfg_pkg::addr_t                   fetch_addr_i,
  output logic                                    fetch_ready_o,
  output logic                                    fetch_valid_o,
  output logic                                    mem_req_o,
  input  logic                                    mem_ack_i,
  output icache_cfg_pkg::addr_t                   mem_addr_o,
  output logic                                    mem_nc_o,
  input  logic                                    mem_rtrn_valid_i,
  input  icache_mem_pkg::rtrn_type_e              mem_rtrn_type_i,
  input  icache_cfg_pkg::set_idx_t                inv_idx_i,
  input  icache_cfg_pkg::way_oh_t                 hit_i,
  output logic                                    rd_en_o,
  output logic                                    fill_en_o,
  output logic                                    inv_en_o,
  output logic                                    flush_en_o,
  output icache_cfg_pkg::set_idx_t                set_o,
  output icache_cfg_pkg::tag_t                    tag_o,
  output logic [icache_cfg_pkg::OffsetWidth-3:0]  offset_o,
  output logic                                    bypass_o
);
  import icache_cfg_pkg::*;
  import icache_mem_pkg::*;

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

  state_e   state_d, state_q;
  addr_t    addr_q;
  set_idx_t flush_cnt_q;
  logic     flush_done;
  logic     flush_d, flush_q;
  logic     cache_en_d, cache_en_q;
  logic     inv_q;
  logic     req_q;
  logic     cmp_q;
  logic     accept;
  logic     nc;
  logic     hit_ok;

  assign accept = fetch_req_i & fetch_ready_o;
  // disabled cache or io region both use the miss path
  assign nc     = ~cache_en_q | (addr_q >= NcBase);
  // a hit read before an invalidation is not trusted
  assign hit_ok = (|hit_i) & ~nc & ~inv_q;
  assign busy_o = (state_q != IDLE);

  ////////////////////
  // address plumbing
  ////////////////////

  assign tag_o    = addr_q[AddrWidth-1 -: TagWidth];
  assign offset_o = addr_q[OffsetWidth-1:2];
  // line aligned for fills, word aligned for nc
  assign mem_addr_o = nc ? {addr_q[AddrWidth-1:2], 2'b00}
                         : {addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  assign mem_nc_o   = nc;
  // flush counter beats invalidations, which beat the fetch index
  assign set_o = flush_en_o ? flush_cnt_q :
                 inv_en_o   ? inv_idx_i   :
                 accept     ? fetch_addr_i[OffsetWidth +: IndexWidth] :
                              addr_q[OffsetWidth +: IndexWidth];
  assign inv_en_o   = mem_rtrn_valid_i & (mem_rtrn_type_i == INV_REQ);
  assign flush_done = (flush_cnt_q == set_idx_t'(NumSets - 1));
  // array output selected only in the cycle after a read
  assign bypass_o   = ~cmp_q;

  ////////////////////
  // main FSM
  ////////////////////

  always_comb begin
    state_d       = state_q;
    cache_en_d    = cache_en_q;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    rd_en_o       = 1'b0;
    fill_en_o     = 1'b0;
    flush_en_o    = 1'b0;
    unique case (state_q)
      // walk all sets, clearing valid bits
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        // disable takes effect at once, enable goes through FLUSH
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_valid_i) begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      READ: begin
        if (inv_q && !req_q) begin
          // arrays changed under us, look again
          rd_en_o = 1'b1;
        end else if (hit_ok) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // back to back hits, unless a flush or return is in the way
          if (!flush_d && !mem_rtrn_valid_i) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              rd_en_o = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // nc data is passed on but never written
        if (mem_rtrn_valid_i && mem_rtrn_type_i == IFILL_ACK) begin
          fetch_valid_o = 1'b1;
          fill_en_o     = ~nc;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_cnt_q <= '0;
      flush_q     <= 1'b0;
      cache_en_q  <= 1'b0;
      inv_q       <= 1'b0;
      req_q       <= 1'b0;
      cmp_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      cache_en_q  <= cache_en_d;
      inv_q       <= inv_en_o;
      // request raised but not yet taken
      req_q       <= mem_req_o & ~mem_ack_i;
      cmp_q       <= rd_en_o;
      if (flush_en_o) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

  // fetch address, held for the whole lookup and refill
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

/* hw/icache_top.sv */
// top of the four way instruction cache
// fetch port on one side, memory request and return ports on the other
`timescale 1ns/1ns

module icache_top #(
  parameter icache_cfg_pkg::addr_t NcBase   = 32'h8000_0000,
  parameter logic [7:0]            LfsrSeed = 8'hA5
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          en_i,
  output logic                          busy_o,
  output logic                          miss_o,
  // fetch port
  input  logic                          fetch_req_i,
  input  icache_cfg_pkg::addr_t         fetch_addr_i,
  output logic                          fetch_ready_o,
  output logic                          fetch_valid_o,
  output icache_cfg_pkg::word_t         fetch_data_o,
  // memory request port
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  output icache_cfg_pkg::addr_t         mem_addr_o,
  output logic                          mem_nc_o,
  // memory return port, never stalled
  input  logic                          mem_rtrn_valid_i,
  input  icache_mem_pkg::rtrn_type_e    mem_rtrn_type_i,
  input  icache_mem_pkg::rtrn_payload_u mem_rtrn_payload_i
);
  import icache_cfg_pkg::*;

  // array control from the FSM
  logic     rd_en;
  logic     fill_en;
  logic     inv_en;
  logic     flush_en;
  logic     bypass;
  set_idx_t set;
  tag_t     tag;
  logic [OffsetWidth-3:0] offset;
  // lookup results
  way_oh_t  hit;
  way_oh_t  valid;
  way_oh_t  victim;

  icache_ctrl #(
    .NcBase (NcBase)
  ) i_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .en_i             (en_i),
    .busy_o           (busy_o),
    .miss_o           (miss_o),
    .fetch_req_i      (fetch_req_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_ready_o    (fetch_ready_o),
    .fetch_valid_o    (fetch_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_ack_i        (mem_ack_i),
    .mem_addr_o       (mem_addr_o),
    .mem_nc_o         (mem_nc_o),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_type_i  (mem_rtrn_type_i),
    .inv_idx_i        (mem_rtrn_payload_i.inv.idx),
    .hit_i            (hit),
    .rd_en_o          (rd_en),
    .fill_en_o        (fill_en),
    .inv_en_o         (inv_en),
    .flush_en_o       (flush_en),
    .set_o            (set),
    .tag_o            (tag),
    .offset_o         (offset),
    .bypass_o         (bypass)
  );

  icache_tag_array i_tag_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_en_i    (rd_en),
    .fill_en_i  (fill_en),
    .inv_en_i   (inv_en),
    .flush_en_i (flush_en),
    .set_i      (set),
    .tag_i      (tag),
    .victim_i   (victim),
    .inv_i      (mem_rtrn_payload_i.inv),
    .hit_o      (hit),
    .valid_o    (valid)
  );

  icache_data_array i_data_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .fill_en_i    (fill_en),
    .set_i        (set),
    .victim_i     (victim),
    .hit_i        (hit),
    .offset_i     (offset),
    .bypass_i     (bypass),
    .fill_line_i  (mem_rtrn_payload_i.line),
    .fetch_data_o (fetch_data_o)
  );

  // compare cycle is the one where the array output is not bypassed
  icache_repl #(
    .LfsrSeed (LfsrSeed)
  ) i_repl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (valid),
    .fill_en_i (fill_en),
    .cmp_en_i  (~bypass),
    .victim_o  (victim)
  );

endmodule

/* dv/icache_tb_model.svh */
// reference model for the instruction cache testbench: backing memory and expected fetches
// included inside the testbench module, after the package imports and NcBase
`ifndef ICACHE_TB_MODEL_SVH
`define ICACHE_TB_MODEL_SVH

////////////////////
// backing memory
////////////////////

// every word is a scramble of its own full word address
function automatic word_t mem_word(input addr_t addr);
  addr_t a;
  a = {addr[AddrWidth-1:2], 2'b00};
  return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h0BAD_F00D;
endfunction

// whole line around an address, word 0 in the low bits
function automatic line_t mem_line(input addr_t addr);
  line_t line;
  addr_t base;
  base = {addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  for (int i = 0; i < LineWidth / FetchWidth; i++) begin
    line[i*FetchWidth +: FetchWidth] = mem_word(base + addr_t'(i * 4));
  end
  return line;
endfunction

////////////////////
// fetch model
////////////////////

// io region or a disabled cache bypasses the arrays
function automatic logic expected_nc(input addr_t addr, input logic en);
  return !en || (addr >= NcBase);
endfunction

// fills ask for the whole line, nc reads for one word
function automatic addr_t expected_mem_addr(input addr_t addr, input logic nc);
  if (nc) begin
    return {addr[AddrWidth-1:2], 2'b00};
  end
  return {addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
endfunction

function automatic set_idx_t set_of(input addr_t addr);
  return addr[OffsetWidth +: IndexWidth];
endfunction

`endif

/* dv/tb_icache_top.sv */
// testbench for the instruction cache top level
// drives fetches, answers memory requests and checks every returned word against the model
`timescale 1ns/1ns

module tb_icache_top;
  import icache_cfg_pkg::*;
  import icache_mem_pkg::*;

  localparam addr_t       NcBase        = 32'h8000_0000;
  localparam logic [7:0]  LfsrSeed      = 8'hA5;
  localparam int          Seed          = 32'hbf6b2c24;
  localparam int          AcceptTimeout = 4 * NumSets;
  localparam int          FetchTimeout  = 32;
  localparam int          BusyTimeout   = NumSets + 16;
  localparam int          InvTimeout    = 8;
  // two lines and two io words used by the directed tests
  localparam addr_t       LineA         = 32'h0000_1238;
  localparam addr_t       LineB         = 32'h0004_5670;
  localparam addr_t       IoA           = 32'h8000_0104;
  localparam addr_t       IoB           = 32'hC001_0208;
  // five lines that share one set
  localparam addr_t       SetBase       = 32'h0002_0050;
  localparam addr_t       LineStride    = 32'h0010_0000;

  typedef enum int {
    EXPECT_HIT,
    EXPECT_REQ,
    EXPECT_ANY
  } fetch_kind_e;

  logic          clk_i;
  logic          rst_ni;
  logic          flush_i;
  logic          en_i;
  logic          busy_o;
  logic          miss_o;
  logic          fetch_req_i;
  addr_t         fetch_addr_i;
  logic          fetch_ready_o;
  logic          fetch_valid_o;
  word_t         fetch_data_o;
  logic          mem_req_o;
  logic          mem_ack_i;
  addr_t         mem_addr_o;
  logic          mem_nc_o;
  logic          mem_rtrn_valid_i;
  rtrn_type_e    mem_rtrn_type_i;
  rtrn_payload_u mem_rtrn_payload_i;

  word_t         exp_q[$];
  rtrn_payload_u inv_queue[$];
  // model view of the fetch in flight, io or disabled
  logic          exp_nc = 1'b0;
  integer        stim_seed = Seed;
  integer        rsp_seed = Seed ^ 32'h5555_5555;

  `include "icache_tb_model.svh"

  icache_top #(
    .NcBase   (NcBase),
    .LfsrSeed (LfsrSeed)
  ) DUT (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .en_i               (en_i),
    .busy_o             (busy_o),
    .miss_o             (miss_o),
    .fetch_req_i        (fetch_req_i),
    .fetch_addr_i       (fetch_addr_i),
    .fetch_ready_o      (fetch_ready_o),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_data_o       (fetch_data_o),
    .mem_req_o          (mem_req_o),
    .mem_ack_i          (mem_ack_i),
    .mem_addr_o         (mem_addr_o),
    .mem_nc_o           (mem_nc_o),
    .mem_rtrn_valid_i   (mem_rtrn_valid_i),
    .mem_rtrn_type_i    (mem_rtrn_type_i),
    .mem_rtrn_payload_i (mem_rtrn_payload_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // error handling
  ////////////////////

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time));
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time));
    end
  endtask

  ////////////////////
  // memory side
  ////////////////////

  // answers one request at a time, invalidations only go out while no request is open
  initial begin : mem_responder
    int    delay;
    addr_t req_addr;
    logic  req_nc;
    mem_ack_i          = 1'b0;
    mem_rtrn_valid_i   = 1'b0;
    mem_rtrn_type_i    = IFILL_ACK;
    mem_rtrn_payload_i = '0;
    forever begin
      @(posedge clk_i);
      mem_ack_i        <= 1'b0;
      mem_rtrn_valid_i <= 1'b0;
      if (inv_queue.size() != 0) begin
        mem_rtrn_valid_i   <= 1'b1;
        mem_rtrn_type_i    <= INV_REQ;
        mem_rtrn_payload_i <= inv_queue.pop_front();
      end else if (rst_ni && mem_req_o) begin
        req_addr = mem_addr_o;
        req_nc   = mem_nc_o;
        delay    = $unsigned($random(rsp_seed)) % 4;
        // request has to stay put until it is taken
        for (int i = 0; i < delay; i++) begin
          @(posedge clk_i);
          compare_bit("mem_req_o", mem_req_o, 1'b1);
          compare_addr("mem_addr_o", mem_addr_o, req_addr);
          compare_bit("mem_nc_o", mem_nc_o, req_nc);
        end
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        compare_bit("mem_req_o", mem_req_o, 1'b1);
        compare_addr("mem_addr_o", mem_addr_o, req_addr);
        compare_bit("mem_nc_o", mem_nc_o, req_nc);
        mem_ack_i <= 1'b0;
        @(posedge clk_i);
        // fill beat two cycles after the ack
        mem_rtrn_valid_i   <= 1'b1;
        mem_rtrn_type_i    <= IFILL_ACK;
        mem_rtrn_payload_i <= mem_line(req_addr);
      end
    end
  end

  ////////////////////
  // result checkers
  ////////////////////

  always @(posedge clk_i) begin : fetch_checker
    word_t exp;
    if (rst_ni && fetch_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_run("fetch_valid_o pulsed while no fetch was outstanding");
      end else begin
        exp = exp_q.pop_front();
        compare_word("fetch_data_o", fetch_data_o, exp);
      end
    end
  end

  // a miss is counted exactly when a cacheable request is taken
  always @(posedge clk_i) begin : miss_monitor
    if (rst_ni && miss_o && !(mem_req_o && mem_ack_i)) begin
      stop_run("miss_o pulsed without an acknowledged memory request");
    end
    if (rst_ni && mem_req_o && mem_ack_i) begin
      compare_bit("miss_o", miss_o, ~exp_nc);
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic fetch(input addr_t addr, input fetch_kind_e kind);
    int   n;
    logic saw_req;
    logic saw_miss;
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > AcceptTimeout) begin
        stop_run($sformatf("timeout: fetch of 0x%h was never accepted", addr));
      end
    end while (!fetch_ready_o);
    fetch_req_i <= 1'b0;
    exp_q.push_back(mem_word(addr));
    exp_nc = expected_nc(addr, en_i);
    if (kind == EXPECT_HIT) begin
      // hit data is due in the very next cycle
      @(posedge clk_i);
      compare_bit("fetch_valid_o", fetch_valid_o, 1'b1);
      compare_bit("mem_req_o", mem_req_o, 1'b0);
    end else begin
      saw_req  = 1'b0;
      saw_miss = 1'b0;
      n        = 0;
      do begin
        @(posedge clk_i);
        n++;
        if (mem_req_o && !saw_req) begin
          saw_req = 1'b1;
          compare_addr("mem_addr_o", mem_addr_o, expected_mem_addr(addr, exp_nc));
          compare_bit("mem_nc_o", mem_nc_o, exp_nc);
        end
        saw_miss = saw_miss | miss_o;
        if (n > FetchTimeout) begin
          stop_run($sformatf("timeout: no fetch_valid_o for the fetch of 0x%h", addr));
        end
      end while (!fetch_valid_o);
      if (kind == EXPECT_REQ) begin
        compare_bit("mem_req_o", saw_req, 1'b1);
      end
      compare_bit("miss_o", saw_miss, saw_req & ~exp_nc);
    end
  endtask

  task automatic send_inv(input logic all, input logic [WayIdxWidth-1:0] way,
                          input set_idx_t idx);
    rtrn_payload_u p;
    int            n;
    p         = '0;
    p.inv.all = all;
    p.inv.vld = ~all;
    p.inv.way = way;
    p.inv.idx = idx;
    @(negedge clk_i);
    inv_queue.push_back(p);
    n = 0;
    while (inv_queue.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > InvTimeout) begin
        stop_run("timeout: invalidation was never sent");
      end
    end
  endtask

  task automatic wait_busy(input logic level, input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > BusyTimeout) begin
        stop_run($sformatf("timeout: busy_o never went to %0d %s", level, what));
      end
    end while (busy_o !== level);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : test_sequence
    int line_sel;
    int word_sel;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    en_i         = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reset flush runs first, nothing else moves
    @(posedge clk_i);
    compare_bit("busy_o", busy_o, 1'b1);
    compare_bit("fetch_ready_o", fetch_ready_o, 1'b0);
    compare_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    compare_bit("mem_req_o", mem_req_o, 1'b0);
    compare_bit("miss_o", miss_o, 1'b0);
    wait_busy(1'b0, "after reset");
    fetch(LineA, EXPECT_REQ);

    // rest of the same line, low address bits ignored
    fetch(LineA - 32'h8, EXPECT_HIT);
    fetch(LineA + 32'h7, EXPECT_HIT);
    fetch(LineA - 32'h4, EXPECT_HIT);

    // io region and a disabled cache never fill
    fetch(IoA, EXPECT_REQ);
    fetch(IoA, EXPECT_REQ);
    fetch(IoB, EXPECT_REQ);
    @(posedge clk_i);
    en_i <= 1'b0;
    fetch(LineA, EXPECT_REQ);
    fetch(LineA, EXPECT_REQ);
    @(posedge clk_i);
    en_i <= 1'b1;
    wait_busy(1'b1, "on enable");
    wait_busy(1'b0, "after the enable flush");
    fetch(LineA, EXPECT_REQ);
    fetch(LineA, EXPECT_HIT);

    // invalidations, LineA sits in way 0
    send_inv(1'b1, '0, set_of(LineA));
    fetch(LineA, EXPECT_REQ);
    fetch(LineA, EXPECT_HIT);
    send_inv(1'b0, 2'd1, set_of(LineA));
    fetch(LineA, EXPECT_HIT);
    send_inv(1'b0, 2'd0, set_of(LineA));
    fetch(LineA, EXPECT_REQ);
    fetch(LineA, EXPECT_HIT);

    // flush while idle drops both lines
    fetch(LineB, EXPECT_REQ);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_busy(1'b1, "on flush_i");
    wait_busy(1'b0, "after flush_i");
    fetch(LineA, EXPECT_REQ);
    fetch(LineB, EXPECT_REQ);
    fetch(LineA, EXPECT_HIT);
    fetch(LineB, EXPECT_HIT);

    // five lines fighting over four ways
    for (int i = 0; i < 80; i++) begin
      line_sel = $unsigned($random(stim_seed)) % 5;
      word_sel = $unsigned($random(stim_seed)) % 4;
      fetch(SetBase + addr_t'(line_sel) * LineStride + addr_t'(word_sel * 4), EXPECT_ANY);
    end

    @(posedge clk_i);
    if (exp_q.size() != 0) begin
      stop_run("fetch results still outstanding at the end");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* icache_top.f */
+incdir+dv
hw/icache_cfg_pkg.sv
hw/icache_mem_pkg.sv
hw/icache_repl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/icache_top.sv
dv/tb_icache_top.sv

/* Bender.yml */
package:
  name: icache

sources:
  # packages first, then the blocks, then the top level
  - files:
      - hw/icache_cfg_pkg.sv
      - hw/icache_mem_pkg.sv
      - hw/icache_repl.sv
      - hw/icache_tag_array.sv
      - hw/icache_data_array.sv
      - hw/icache_ctrl.sv
      - hw/icache_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_icache_top.sv
